// ==== verification/i2c_rx_stimulus.txt ====
// start b2b phase sar ten gcall_en enable data_nack byte | ack match push gcall
// hex fields; phase 0 addr1, 1 addr2, 2 data; ack 1 means SDA pulled low in the ninth bit
1 0 0 052 0 0 1 0 a4  1 1 0 0
1 0 0 052 0 0 1 0 a5  1 1 0 0
1 0 0 052 0 0 1 0 a6  1 1 0 0
1 0 0 052 0 0 1 0 a0  0 0 0 0
1 1 0 052 0 0 1 0 a4  1 1 0 0
0 1 2 052 0 0 1 0 3c  1 0 1 0
0 0 2 052 0 0 1 1 5a  0 0 0 0
1 0 0 052 0 1 1 0 00  1 1 0 1
1 0 0 052 0 0 1 0 00  0 0 0 0
1 1 0 2b7 1 0 1 0 f4  1 1 0 0
0 0 1 2b7 1 0 1 0 b7  1 1 0 0
1 1 0 2b7 1 0 1 0 f4  1 1 0 0
0 0 1 2b7 1 0 1 0 b6  0 0 0 0
1 0 0 052 0 1 0 0 a4  0 0 0 0
1 0 0 052 0 1 0 0 00  0 0 0 0
1 1 0 2b7 1 0 0 0 f4  0 0 0 0
0 0 1 2b7 1 0 0 0 b7  0 0 0 0
1 0 2 052 0 0 0 0 e1  0 0 1 0

// ==== vlog.f ====
hdl/i2c_rx_pkg.sv
hdl/i2c_line_sync.sv
hdl/i2c_rx_shifter.sv
hdl/i2c_slv_addr_match.sv
hdl/i2c_slv_rx.sv
verification/tb_i2c_slv_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the I2C slave receive testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_i2c_slv_rx -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_i2c_slv_rx)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== verification/tb_i2c_slv_rx.sv ====
/*
 * testbench for the I2C slave receive path
 * bit-bangs one byte slot per stimulus line and checks the ACK drive,
 * address match, received byte and the push, done and general call pulses
 */
`timescale 1ns/1ps

module tb_i2c_slv_rx
    import i2c_rx_pkg::*;
();

    localparam int    NCOL        = 13;
    localparam int    MAX_LINES   = 64;
    localparam int    HALF        = 16;
    localparam int    NS_PER_LINE = 9 * 32 * 8 * 2;
    localparam string STIM_FILE   = "verification/i2c_rx_stimulus.txt";

    // column order of one stimulus line
    localparam int C_START = 0;
    localparam int C_B2B   = 1;
    localparam int C_PHASE = 2;
    localparam int C_SAR   = 3;
    localparam int C_TEN   = 4;
    localparam int C_GCEN  = 5;
    localparam int C_EN    = 6;
    localparam int C_DNACK = 7;
    localparam int C_BYTE  = 8;
    localparam int C_ACK   = 9;
    localparam int C_MATCH = 10;
    localparam int C_PUSH  = 11;
    localparam int C_GCALL = 12;

    logic      i2c_clk = 1'b0;
    logic      i2c_rst_n;
    logic      scl_in;
    logic      sda_in;
    logic      rx_en;
    rx_phase_t rx_phase;
    logic      b2b_rx;
    slv_cfg_t  cfg;
    rx_byte_u  rx_byte;
    logic      push_rx_fifo;
    logic      shift_done;
    logic      sda_out;
    logic      addr_match;
    logic      gen_call_rcvd;
    logic      rx_ack_phase;

    logic [11:0] stim_mem [0:NCOL*MAX_LINES-1];
    logic [7:0]  lfsr      = 8'd21;
    int          n_lines   = 0;
    int          error_cnt = 0;
    int          check_cnt = 0;
    int          push_cnt  = 0;
    int          done_cnt  = 0;
    int          gcall_cnt = 0;

    i2c_slv_rx #(
        .ADDR_STEAL_BITS (1)
    ) u_i2c_slv_rx (
        .i2c_clk       (i2c_clk),
        .i2c_rst_n     (i2c_rst_n),
        .scl_in        (scl_in),
        .sda_in        (sda_in),
        .rx_en         (rx_en),
        .rx_phase      (rx_phase),
        .b2b_rx        (b2b_rx),
        .cfg           (cfg),
        .rx_byte       (rx_byte),
        .push_rx_fifo  (push_rx_fifo),
        .shift_done    (shift_done),
        .sda_out       (sda_out),
        .addr_match    (addr_match),
        .gen_call_rcvd (gen_call_rcvd),
        .rx_ack_phase  (rx_ack_phase)
    );

    always #4 i2c_clk = ~i2c_clk;

    // pulse counters sampled away from the driving edge
    always @(negedge i2c_clk) begin
        if (i2c_rst_n) begin
            if (push_rx_fifo)
                push_cnt <= push_cnt + 1;
            if (shift_done)
                done_cnt <= done_cnt + 1;
            if (gen_call_rcvd)
                gcall_cnt <= gcall_cnt + 1;
        end
    end

    // taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic next_gap(output int gap);
        gap = 0;
        for (int i = 0; i < 4; i++) begin
            lfsr = lfsr_step(lfsr);
            gap  = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i2c_clk);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_cnt++;
        if (got !== expected) begin
            error_cnt++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic check_pulses(input string name, input int row, input int count,
                                input int expected);
        if (expected > 0 && count == 0) begin
            error_cnt++;
            $display("slot %0d expected a %s pulse but none was seen", row, name);
        end else begin
            check_equal(name, count, expected);
        end
    endtask

    task automatic send_bit(input logic b);
        scl_in <= 1'b0;
        wait_cycles(4);
        sda_in <= b;
        wait_cycles(HALF - 4);
        scl_in <= 1'b1;
        wait_cycles(HALF);
    endtask

    task automatic run_slot(input int row);
        logic [11:0] col [NCOL];
        logic [7:0]  data;
        logic        exp_sda;
        int          gap;
        int          push_start;
        int          gcall_start;
        int          done_start;
        int          waited;
        for (int c = 0; c < NCOL; c++)
            col[c] = stim_mem[row * NCOL + c];
        data    = col[C_BYTE][7:0];
        exp_sda = ~col[C_ACK][0];
        // a fresh transaction drops rx_en so the FSM restarts from IDLE
        if (col[C_START][0]) begin
            rx_en  <= 1'b0;
            scl_in <= 1'b1;
            sda_in <= 1'b1;
            next_gap(gap);
            wait_cycles(4 + gap);
        end
        rx_phase         <= rx_phase_t'(col[C_PHASE][1:0]);
        b2b_rx           <= col[C_B2B][0];
        cfg.sar          <= col[C_SAR][9:0];
        cfg.ten_bit      <= col[C_TEN][0];
        cfg.ack_gen_call <= col[C_GCEN][0];
        cfg.enable       <= col[C_EN][0];
        cfg.data_nack    <= col[C_DNACK][0];
        push_start  = push_cnt;
        gcall_start = gcall_cnt;
        done_start  = done_cnt;
        if (col[C_START][0]) begin
            rx_en <= 1'b1;
            wait_cycles(HALF);
            sda_in <= 1'b0;
            wait_cycles(HALF);
        end
        for (int i = 7; i >= 0; i--)
            send_bit(data[i]);
        // SDA is released to the slave for the ninth clock
        scl_in <= 1'b0;
        wait_cycles(4);
        sda_in <= 1'b1;
        wait_cycles(HALF - 4);
        scl_in <= 1'b1;
        wait_cycles(HALF / 2);
        @(negedge i2c_clk);
        check_equal("sda_out", 32'(sda_out), 32'(exp_sda));
        check_equal("addr_match", 32'(addr_match), 32'(col[C_MATCH][0]));
        check_equal("rx_ack_phase", 32'(rx_ack_phase), 32'd1);
        if (col[C_PHASE][1:0] == 2'd2) begin
            check_equal("rx_byte.data", 32'(rx_byte.data), 32'(data));
        end else begin
            check_equal("rx_byte.addr.addr7", 32'(rx_byte.addr.addr7), 32'(data[7:1]));
            check_equal("rx_byte.addr.rw", 32'(rx_byte.addr.rw), 32'(data[0]));
        end
        wait_cycles(HALF / 2);
        scl_in <= 1'b0;
        waited = 0;
        while (done_cnt == done_start && waited < 32) begin
            wait_cycles(1);
            waited++;
        end
        wait_cycles(2);
        @(negedge i2c_clk);
        check_pulses("shift_done", row, done_cnt - done_start, 1);
        check_pulses("push_rx_fifo", row, push_cnt - push_start, int'(col[C_PUSH][0]));
        check_pulses("gen_call_rcvd", row, gcall_cnt - gcall_start, int'(col[C_GCALL][0]));
        check_equal("sda_out", 32'(sda_out), 32'd1);
        wait_cycles(1);
    endtask

    initial begin
        i2c_rst_n = 1'b0;
        scl_in    = 1'b1;
        sda_in    = 1'b1;
        rx_en     = 1'b0;
        rx_phase  = PH_ADDR1;
        b2b_rx    = 1'b0;
        cfg       = '0;
        for (int i = 0; i < NCOL * MAX_LINES; i++)
            stim_mem[i] = '1;
        $readmemh(STIM_FILE, stim_mem);
        while (n_lines < MAX_LINES && stim_mem[n_lines * NCOL + C_PHASE] != 12'hfff)
            n_lines++;
        if (n_lines == 0) begin
            error_cnt++;
            $display("no transactions could be read from %s", STIM_FILE);
        end
        wait_cycles(2);
        i2c_rst_n <= 1'b1;
        wait_cycles(2);
        for (int row = 0; row < n_lines; row++)
            run_slot(row);
        wait_cycles(4);
        $display("checks: %0d errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        wait (n_lines > 0);
        #(n_lines * NS_PER_LINE);
        $display("watchdog expired before all %0d slots were sent", n_lines);
        $display("checks: %0d errors: %0d", check_cnt, error_cnt);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== hdl/i2c_slv_rx.sv ====
/*
 * I2C slave receive path
 * line synchronizer, receive shifter and address match joined into
 * the slave side byte receiver
 */
`timescale 1ns/1ps

module i2c_slv_rx
    import i2c_rx_pkg::*;
#(
    parameter int unsigned ADDR_STEAL_BITS = 0
) (
    input  logic      i2c_clk,
    input  logic      i2c_rst_n,
    input  logic      scl_in,
    input  logic      sda_in,
    input  logic      rx_en,
    input  rx_phase_t rx_phase,
    input  logic      b2b_rx,
    input  slv_cfg_t  cfg,
    output rx_byte_u  rx_byte,
    output logic      push_rx_fifo,
    output logic      shift_done,
    output logic      sda_out,
    output logic      addr_match,
    output logic      gen_call_rcvd,
    output logic      rx_ack_phase
);

    line_evt_t evt;
    logic      ack_val;

    i2c_line_sync u_line_sync (
        .i2c_clk   (i2c_clk),
        .i2c_rst_n (i2c_rst_n),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .evt       (evt)
    );

    i2c_rx_shifter u_rx_shifter (
        .i2c_clk      (i2c_clk),
        .i2c_rst_n    (i2c_rst_n),
        .evt          (evt),
        .rx_en        (rx_en),
        .rx_phase     (rx_phase),
        .b2b_rx       (b2b_rx),
        .data_nack    (cfg.data_nack),
        .ack_val      (ack_val),
        .rx_byte      (rx_byte),
        .push_rx_fifo (push_rx_fifo),
        .shift_done   (shift_done),
        .rx_ack_phase (rx_ack_phase),
        .sda_out      (sda_out)
    );

    i2c_slv_addr_match #(
        .ADDR_STEAL_BITS (ADDR_STEAL_BITS)
    ) u_addr_match (
        .rx_byte       (rx_byte),
        .rx_phase      (rx_phase),
        .cfg           (cfg),
        .shift_done    (shift_done),
        .ack_val       (ack_val),
        .addr_match    (addr_match),
        .gen_call_rcvd (gen_call_rcvd)
    );

endmodule

// ==== hdl/i2c_slv_addr_match.sv ====
/*
 * I2C slave address match
 * checks the received byte against the slave address, the 10-bit
 * prefix and the general call and picks the ACK value for the slot
 */
`timescale 1ns/1ps

module i2c_slv_addr_match
    import i2c_rx_pkg::*;
#(
    parameter int unsigned ADDR_STEAL_BITS = 0
) (
    input  rx_byte_u  rx_byte,
    input  rx_phase_t rx_phase,
    input  slv_cfg_t  cfg,
    input  logic      shift_done,
    output logic      ack_val,
    output logic      addr_match,
    output logic      gen_call_rcvd
);

    // stolen low address bits are left out of the 7-bit compare
    localparam logic [6:0] STEAL_MASK = 7'h7f << ADDR_STEAL_BITS;

    logic seven_hit;
    logic ten_hi_hit;
    logic ten_lo_hit;
    logic gcall_hit;
    logic addr_phase;
    logic data_ack_val;

    assign seven_hit  = ~cfg.ten_bit &
                        ((rx_byte.addr.addr7 & STEAL_MASK) == (cfg.sar[6:0] & STEAL_MASK));

    // the rw bit of the first 10-bit byte is not part of the compare
    assign ten_hi_hit = cfg.ten_bit &
                        (rx_byte.addr.addr7 == {TENBIT_PREFIX, cfg.sar[9:8]});

    assign ten_lo_hit = cfg.ten_bit & (rx_byte.data == cfg.sar[7:0]);

    assign gcall_hit  = cfg.ack_gen_call & (rx_byte.data == '0);

    assign addr_match = cfg.enable &
                        (((rx_phase == PH_ADDR1) & (seven_hit | ten_hi_hit | gcall_hit)) |
                         ((rx_phase == PH_ADDR2) & ten_lo_hit));

    assign addr_phase   = (rx_phase == PH_ADDR1) || (rx_phase == PH_ADDR2);
    assign data_ack_val = cfg.data_nack | ~cfg.enable;

    // 0 pulls SDA low for ACK
    assign ack_val = addr_phase ? ~addr_match : data_ack_val;

    assign gen_call_rcvd = cfg.enable & shift_done & (rx_phase == PH_ADDR1) & gcall_hit;

endmodule

// ==== hdl/i2c_rx_shifter.sv ====
/*
 * I2C slave receive shifter
 * counts the nine bits of a slot, shifts in the byte MSB first,
 * drives the ACK bit and pulses done and FIFO push strobes
 */
`timescale 1ns/1ps

module i2c_rx_shifter
    import i2c_rx_pkg::*;
(
    input  logic      i2c_clk,
    input  logic      i2c_rst_n,
    input  line_evt_t evt,
    input  logic      rx_en,
    input  rx_phase_t rx_phase,
    input  logic      b2b_rx,
    input  logic      data_nack,
    input  logic      ack_val,
    output rx_byte_u  rx_byte,
    output logic      push_rx_fifo,
    output logic      shift_done,
    output logic      rx_ack_phase,
    output logic      sda_out
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        SHIFT = 2'd1,
        DONE  = 2'd2
    } rx_state_t;

    localparam logic [3:0] CNT_SLOT = 4'(I2C_SLOT_BITS);
    localparam logic [3:0] CNT_BYTE = 4'(I2C_BYTE_W);

    rx_state_t                 state;
    rx_state_t                 state_nxt;
    logic      [3:0]           cnt;
    logic      [3:0]           cnt_nxt;
    logic      [2:0]           bit_idx;
    logic      [I2C_BYTE_W-1:0] shift_q;
    logic                      ack_drive;
    logic                      ack_flag;
    logic                      ack_flag_dly;
    logic                      done_flag;
    logic                      done_flag_dly;

    always_comb begin
        case (state)
            IDLE:    state_nxt = rx_en ? SHIFT : IDLE;
            SHIFT: begin
                if (!rx_en)
                    state_nxt = IDLE;
                else if (cnt == 4'd0 && evt.scl_fall)
                    state_nxt = DONE;
                else
                    state_nxt = SHIFT;
            end
            DONE: begin
                if (!rx_en)
                    state_nxt = IDLE;
                else if (b2b_rx)
                    state_nxt = SHIFT;
                else
                    state_nxt = DONE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    // a START leaves one SCL fall before the first data bit, hence nine
    always_comb begin
        if (evt.start_det || state == IDLE)
            cnt_nxt = CNT_SLOT;
        else if (state == DONE && state_nxt == SHIFT)
            cnt_nxt = CNT_BYTE;
        else if (state == SHIFT && evt.scl_fall && cnt != 4'd0)
            cnt_nxt = cnt - 4'd1;
        else
            cnt_nxt = cnt;
    end

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            state <= IDLE;
            cnt   <= CNT_BYTE;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
        end
    end

    // counts 8 down to 1 address bits 7 down to 0
    assign bit_idx = cnt[2:0] - 3'd1;

    always_ff @(posedge i2c_clk) begin
        if (state == SHIFT && evt.scl_rise && cnt != 4'd0 && cnt <= CNT_BYTE)
            shift_q[bit_idx] <= evt.sda;
    end

    assign rx_byte.data = shift_q;

    assign ack_drive = (state_nxt == SHIFT) && (cnt_nxt == 4'd0);

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            sda_out       <= 1'b1;
            ack_flag      <= 1'b0;
            ack_flag_dly  <= 1'b0;
            done_flag     <= 1'b0;
            done_flag_dly <= 1'b0;
        end else begin
            sda_out       <= ack_drive ? ack_val : 1'b1;
            ack_flag      <= ack_drive;
            ack_flag_dly  <= ack_flag;
            done_flag     <= (state_nxt == DONE);
            done_flag_dly <= done_flag;
        end
    end

    assign shift_done   = done_flag & ~done_flag_dly;
    assign push_rx_fifo = ack_flag & ~ack_flag_dly & rx_en & ~data_nack &
                          (rx_phase == PH_DATA);
    assign rx_ack_phase = rx_en & (cnt == 4'd0);

    a_cnt_range: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
        cnt <= CNT_SLOT);

    // a push only follows the last bit of a slot that was already a data slot
    a_push_in_data: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
        push_rx_fifo |-> ($past(rx_phase) == PH_DATA) && ($past(cnt) == 4'd1));

endmodule

// ==== hdl/i2c_line_sync.sv ====
/*
 * I2C line synchronizer
 * brings SCL and SDA into the i2c_clk domain and flags SCL edges
 * and START/STOP conditions as one-cycle strobes
 */
`timescale 1ns/1ps

module i2c_line_sync
    import i2c_rx_pkg::*;
(
    input  logic      i2c_clk,
    input  logic      i2c_rst_n,
    input  logic      scl_in,
    input  logic      sda_in,
    output line_evt_t evt
);

    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       scl_dly;
    logic       sda_dly;
    logic       scl_rise_q;
    logic       scl_fall_q;
    logic       start_q;
    logic       stop_q;

    // both lines idle high on an open-drain bus
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            scl_dly  <= 1'b1;
            sda_dly  <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[0], scl_in};
            sda_sync <= {sda_sync[0], sda_in};
            scl_dly  <= scl_sync[1];
            sda_dly  <= sda_sync[1];
        end
    end

    // strobes lag the synchronized levels by one cycle
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_rise_q <= 1'b0;
            scl_fall_q <= 1'b0;
            start_q    <= 1'b0;
            stop_q     <= 1'b0;
        end else begin
            scl_rise_q <= scl_sync[1] & ~scl_dly;
            scl_fall_q <= ~scl_sync[1] & scl_dly;
            start_q    <= scl_sync[1] & scl_dly & sda_dly & ~sda_sync[1];
            stop_q     <= scl_sync[1] & scl_dly & ~sda_dly & sda_sync[1];
        end
    end

    assign evt = '{scl:       scl_sync[1],
                   sda:       sda_sync[1],
                   scl_rise:  scl_rise_q,
                   scl_fall:  scl_fall_q,
                   start_det: start_q,
                   stop_det:  stop_q};

    // SCL keeps each level for more than one cycle so no two edge strobes touch
    a_scl_edges_exclusive: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
        (evt.scl_rise || evt.scl_fall) |=> !(evt.scl_rise || evt.scl_fall));

endmodule

// ==== hdl/i2c_rx_pkg.sv ====
/*
 * I2C slave receive path shared definitions
 * bus event and configuration structs, slot phase encoding and the
 * received byte union seen both as an address and as data
 */
package i2c_rx_pkg;

    parameter int I2C_BYTE_W    = 8;
    parameter int I2C_SLOT_BITS = 9;
    parameter int I2C_SAR_W     = 10;

    // upper five bits of the first byte of a 10-bit address
    parameter logic [4:0] TENBIT_PREFIX = 5'b11110;

    typedef struct packed {
        logic scl;
        logic sda;
        logic scl_rise;
        logic scl_fall;
        logic start_det;
        logic stop_det;
    } line_evt_t;

    typedef struct packed {
        logic [I2C_SAR_W-1:0] sar;
        logic                 ten_bit;
        logic                 ack_gen_call;
        logic                 enable;
        logic                 data_nack;
    } slv_cfg_t;

    // driven by the slave state machine outside this path
    typedef enum logic [1:0] {
        PH_ADDR1 = 2'd0,
        PH_ADDR2 = 2'd1,
        PH_DATA  = 2'd2
    } rx_phase_t;

    typedef struct packed {
        logic [6:0] addr7;
        logic       rw;
    } addr_byte_t;

    typedef union packed {
        addr_byte_t            addr;
        logic [I2C_BYTE_W-1:0] data;
    } rx_byte_u;

endpackage
